// File: build.f
+incdir+verilog
+incdir+test
verilog/dcache_pkg.sv
verilog/fpga_ram.sv
verilog/ct_f_spsram_512x96.sv
verilog/dcache_way_ctrl.sv
verilog/dcache_way_top.sv
test/dcache_way_tb.sv

// File: test/dcache_way_model.svh
`ifndef DCACHE_WAY_MODEL_SVH
`define DCACHE_WAY_MODEL_SVH

// Reference state of the way, one entry per set
logic  m_valid [`DCACHE_SETS];
tag_t  m_tag   [`DCACHE_SETS];
line_t m_line  [`DCACHE_SETS];

// Expected responses, oldest first
logic  exp_hit_q  [$];
line_t exp_line_q [$];
logic  exp_load_q [$];

// Low address bits select the set
function automatic index_t addr_index(input logic [`DCACHE_ADDR_W-1:0] a);
  return a[`DCACHE_INDEX_W-1:0];
endfunction

// Everything above the index is tag
function automatic tag_t addr_tag(input logic [`DCACHE_ADDR_W-1:0] a);
  return a[`DCACHE_ADDR_W-1:`DCACHE_INDEX_W];
endfunction

function automatic logic [`DCACHE_ADDR_W-1:0] make_addr(input tag_t t, input index_t i);
  return {t, i};
endfunction

// Same state reset leaves behind
function automatic void model_reset();
  for (int s = 0; s < `DCACHE_SETS; s++) begin
    m_valid[s] = 1'b0;
    m_tag[s]   = '0;
    m_line[s]  = '0;
  end
endfunction

// Hit means a valid set holding the same tag
function automatic logic expected_hit(input logic [`DCACHE_ADDR_W-1:0] a);
  return m_valid[addr_index(a)] && (m_tag[addr_index(a)] == addr_tag(a));
endfunction

// Lane k sits at bits 24k up to 24k+23
function automatic line_t merge_lanes(input line_t old_line, input line_t new_line,
                                      input lane_mask_t mask);
  line_t result;
  result = old_line;
  for (int k = 0; k < `DCACHE_LANES; k++) begin
    if (mask[k]) begin
      result[k*`DCACHE_LANE_W +: `DCACHE_LANE_W] = new_line[k*`DCACHE_LANE_W +: `DCACHE_LANE_W];
    end
  end
  return result;
endfunction

// Apply one request in issue order and queue its expected answer
function automatic void model_issue(input dcache_op_e o, input logic [`DCACHE_ADDR_W-1:0] a,
                                    input line_t d, input lane_mask_t mask);
  index_t i;
  logic   h;
  i = addr_index(a);
  h = expected_hit(a);
  case (o)
    OP_LOAD: begin
      exp_hit_q.push_back(h);
      exp_line_q.push_back(m_line[i]);
      exp_load_q.push_back(1'b1);
    end
    OP_STORE: begin
      exp_hit_q.push_back(h);
      exp_line_q.push_back(m_line[i]);
      exp_load_q.push_back(1'b0);
      // Miss leaves the line alone
      if (h) begin
        m_line[i] = merge_lanes(m_line[i], d, mask);
      end
    end
    OP_FILL: begin
      m_valid[i] = 1'b1;
      m_tag[i]   = addr_tag(a);
      m_line[i]  = d;
    end
    default: begin
      m_valid[i] = 1'b0;
    end
  endcase
endfunction

`endif

// File: test/dcache_way_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_way_tb;

  import dcache_pkg::*;

  // Issued operations over all tests, sizes the watchdog
  localparam int OPS_PLANNED    = 16 + 24 + 10 + 10 + 6 + 300;
  localparam int TIMEOUT_CYCLES = 3 * OPS_PLANNED + 200;

  logic                      CLK;
  logic                      arst_n;
  logic                      req;
  dcache_op_e                op;
  logic [`DCACHE_ADDR_W-1:0] addr;
  line_t                     wdata;
  lane_mask_t                lane_mask;
  wire                       stall;
  wire                       resp_valid;
  wire                       hit;
  wire line_t                rdata;

  // Bookkeeping
  int          n_errors;
  int          n_checks;
  int          n_tests;
  int          n_failed;
  int          n_issued;
  int          cycle_count;
  int          test_err_base;
  int unsigned seed_dummy;

  // Popped expectation
  logic  cmp_hit;
  line_t cmp_line;
  logic  cmp_load;

  `include "dcache_way_model.svh"

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  dcache_way_top dcache_way_top_inst (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .req        (req),
    .op         (op),
    .addr       (addr),
    .wdata      (wdata),
    .lane_mask  (lane_mask),
    .stall      (stall),
    .resp_valid (resp_valid),
    .hit        (hit),
    .rdata      (rdata)
  );

  // Watchdog
  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Timeout: run went past %0d cycles", TIMEOUT_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // Outputs still hold the response cycle at the rising edge
  always @(posedge CLK) begin
    if (arst_n && resp_valid) begin
      if (exp_hit_q.size() == 0) begin
        $display("%0t: response arrived with no request outstanding", $time);
        n_errors++;
      end else begin
        cmp_hit  = exp_hit_q.pop_front();
        cmp_line = exp_line_q.pop_front();
        cmp_load = exp_load_q.pop_front();
        n_checks++;
        if (hit !== cmp_hit) begin
          $display("FAIL %0t hit expected %0b actual %0b", $time, cmp_hit, hit);
          n_errors++;
        end
        // Line data only counts on a hit
        if (cmp_hit && rdata !== cmp_line) begin
          $display("FAIL %0t rdata expected %h actual %h", $time, cmp_line, rdata);
          n_errors++;
        end
        // Stall covers a store answer, never a load answer
        if (stall !== !cmp_load) begin
          $display("FAIL %0t stall expected %0b actual %0b", $time, !cmp_load, stall);
          n_errors++;
        end
      end
    end
  end

  function automatic line_t rand_line();
    return {$urandom, $urandom, $urandom};
  endfunction

  // One-cycle strobe, held off while a store owns the port
  task automatic issue(input dcache_op_e o, input logic [`DCACHE_ADDR_W-1:0] a,
                       input line_t d, input lane_mask_t m);
    while (stall) begin
      @(negedge CLK);
    end
    req       = 1'b1;
    op        = o;
    addr      = a;
    wdata     = d;
    lane_mask = m;
    model_issue(o, a, d, m);
    n_issued++;
    @(negedge CLK);
    req = 1'b0;
  endtask

  // Wait for outstanding responses
  task automatic drain();
    int waited;
    waited = 0;
    while (exp_hit_q.size() != 0 && waited < 8) begin
      @(negedge CLK);
      waited++;
    end
    if (exp_hit_q.size() != 0) begin
      $display("%0t: %0d expected responses never arrived", $time, exp_hit_q.size());
      n_errors++;
      exp_hit_q.delete();
      exp_line_q.delete();
      exp_load_q.delete();
    end
    @(negedge CLK);
  endtask

  task automatic finish_test(input int num, input string name);
    drain();
    n_tests++;
    if (n_errors == test_err_base) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      n_failed++;
      $display("test %0d %s: %0d errors", num, name, n_errors - test_err_base);
    end
    test_err_base = n_errors;
  endtask

  initial begin
    logic [`DCACHE_ADDR_W-1:0] a;
    logic [`DCACHE_ADDR_W-1:0] b;
    int r;
    seed_dummy    = $urandom(81924);
    arst_n        = 1'b0;
    req           = 1'b0;
    op            = OP_LOAD;
    addr          = '0;
    wdata         = '0;
    lane_mask     = '0;
    n_errors      = 0;
    n_checks      = 0;
    n_tests       = 0;
    n_failed      = 0;
    n_issued      = 0;
    cycle_count   = 0;
    test_err_base = 0;
    model_reset();
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    arst_n = 1'b1;
    @(negedge CLK);

    // Empty way after reset
    for (int k = 0; k < 16; k++) begin
      issue(OP_LOAD, make_addr(tag_t'($urandom), index_t'($urandom)), '0, '0);
    end
    finish_test(1, "loads miss after reset");

    // Eight fills, then back-to-back loads over different sets
    for (int k = 0; k < 8; k++) begin
      issue(OP_FILL, make_addr(tag_t'(11'h100 + k), index_t'(k * 61)), rand_line(), '0);
    end
    for (int k = 0; k < 8; k++) begin
      issue(OP_LOAD, make_addr(tag_t'(11'h100 + k), index_t'(k * 61)), '0, '0);
    end
    // Load right behind its fill
    for (int k = 0; k < 4; k++) begin
      a = make_addr(tag_t'(11'h2a0 + k), index_t'(400 + k));
      issue(OP_FILL, a, rand_line(), '0);
      issue(OP_LOAD, a, '0, '0);
    end
    finish_test(2, "fill then load");

    // Masked stores on a hit line, then a store that misses
    a = make_addr(11'h055, 9'd33);
    b = make_addr(11'h056, 9'd33);
    issue(OP_FILL, a, rand_line(), '0);
    issue(OP_STORE, a, rand_line(), 4'b0101);
    issue(OP_LOAD, a, '0, '0);
    issue(OP_STORE, a, rand_line(), 4'b1010);
    issue(OP_LOAD, a, '0, '0);
    issue(OP_STORE, a, rand_line(), 4'b1000);
    issue(OP_LOAD, a, '0, '0);
    issue(OP_STORE, b, rand_line(), 4'b1111);
    issue(OP_LOAD, a, '0, '0);
    issue(OP_LOAD, b, '0, '0);
    finish_test(3, "store lanes and store miss");

    // New tag in the same set pushes the old line out
    for (int k = 0; k < 2; k++) begin
      a = make_addr(tag_t'(11'h300 + k), index_t'(128 + k));
      b = make_addr(tag_t'(11'h400 + k), index_t'(128 + k));
      issue(OP_FILL, a, rand_line(), '0);
      issue(OP_LOAD, a, '0, '0);
      issue(OP_FILL, b, rand_line(), '0);
      issue(OP_LOAD, a, '0, '0);
      issue(OP_LOAD, b, '0, '0);
    end
    finish_test(4, "eviction by fill");

    a = make_addr(11'h7ff, 9'd511);
    issue(OP_FILL, a, rand_line(), '0);
    issue(OP_LOAD, a, '0, '0);
    issue(OP_INVAL, a, '0, '0);
    issue(OP_LOAD, a, '0, '0);
    issue(OP_FILL, a, rand_line(), '0);
    issue(OP_LOAD, a, '0, '0);
    finish_test(5, "invalidate and refill");

    // Four sets, three tags, all four operations
    for (int n = 0; n < 300; n++) begin
      a = make_addr(tag_t'(11'h010 + $urandom % 3), index_t'(5 + ($urandom % 4) * 97));
      r = $urandom % 10;
      if (r < 4) begin
        issue(OP_LOAD, a, '0, '0);
      end else if (r < 6) begin
        issue(OP_STORE, a, rand_line(), lane_mask_t'($urandom % 16));
      end else if (r < 8) begin
        issue(OP_FILL, a, rand_line(), '0);
      end else begin
        issue(OP_INVAL, a, '0, '0);
      end
    end
    finish_test(6, "random mix");

    $display("Summary: %0d tests, %0d failed, %0d ops, %0d checks, %0d errors",
             n_tests, n_failed, n_issued, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/ct_f_spsram_512x96.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_defines.svh"

module ct_f_spsram_512x96 (
  input  wire                     CLK,
  input  wire dcache_pkg::index_t A,
  input  wire                     CEN,
  input  wire                     GWEN,
  input  wire dcache_pkg::line_t  WEN,
  input  wire dcache_pkg::line_t  D,
  output wire dcache_pkg::line_t  Q
);

  import dcache_pkg::*;

  // Address seen by the lane RAMs
  index_t addr_hold_q;
  index_t ram_addr;

  // Per-lane write strobes, active high
  wire [`DCACHE_LANES-1:0] ram_we;

  // Lane slices in and out
  wire lane_t ram_din  [`DCACHE_LANES];
  wire lane_t ram_dout [`DCACHE_LANES];

  // Remember the last enabled address
  always_ff @(posedge CLK) begin
    if (!CEN) begin
      addr_hold_q <= A;
    end
  end

  // Deselected chip keeps reading the held address
  // so Q does not move while CEN is high
  assign ram_addr = CEN ? addr_hold_q : A;

  for (genvar k = 0; k < `DCACHE_LANES; k++) begin : g_lane

    // Top WEN bit of each lane decides for the whole lane
    assign ram_we[k] = !CEN && !GWEN
                       && !WEN[k*`DCACHE_LANE_W + `DCACHE_LANE_W - 1];

    // Split the write line
    assign ram_din[k] = D[k*`DCACHE_LANE_W +: `DCACHE_LANE_W];

    // One RAM per 24-bit lane
    fpga_ram #(
      .ADDR_WIDTH (`DCACHE_INDEX_W),
      .word_t     (lane_t)
    ) ram_inst (
      .PortAClk         (CLK),
      .PortAAddr        (ram_addr),
      .PortADataIn      (ram_din[k]),
      .PortAWriteEnable (ram_we[k]),
      .PortADataOut     (ram_dout[k])
    );

    // Join lane outputs back into a line
    assign Q[k*`DCACHE_LANE_W +: `DCACHE_LANE_W] = ram_dout[k];

  end

  // Enabled access needs a real address
  a_addr_known : assert property (
    @(posedge CLK) !CEN |-> !$isunknown(A)
  ) else $error("SRAM selected with unknown address");

endmodule

`default_nettype wire

// File: verilog/dcache_defines.svh
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// Set index bits of the line address
`define DCACHE_INDEX_W 9

// One set per SRAM word
`define DCACHE_SETS 512

// Tag bits above the index
`define DCACHE_TAG_W 11

// Full line address
`define DCACHE_ADDR_W 20

// Lane geometry of one line
`define DCACHE_LANES 4
`define DCACHE_LANE_W 24
`define DCACHE_LINE_W 96

`endif

// File: verilog/dcache_pkg.sv
`default_nettype none

`include "dcache_defines.svh"

package dcache_pkg;

  // One lane word of a line
  typedef logic [`DCACHE_LANE_W-1:0] lane_t;

  // Whole line, lane k at bits 24k and up
  typedef logic [`DCACHE_LINE_W-1:0] line_t;

  // Tag and set index of a line address
  typedef logic [`DCACHE_TAG_W-1:0] tag_t;
  typedef logic [`DCACHE_INDEX_W-1:0] index_t;

  // One bit per lane, set means write that lane
  typedef logic [`DCACHE_LANES-1:0] lane_mask_t;

  // Requester operations
  typedef enum logic [1:0] {
    OP_LOAD  = 2'd0,
    OP_STORE = 2'd1,
    OP_FILL  = 2'd2,
    OP_INVAL = 2'd3
  } dcache_op_e;

endpackage

`default_nettype wire

// File: verilog/dcache_way_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_way_ctrl (
  input  wire                         CLK,
  input  wire                         arst_n,
  input  wire                         req,
  input  wire dcache_pkg::dcache_op_e op,
  input  wire [`DCACHE_ADDR_W-1:0]    addr,
  input  wire dcache_pkg::line_t      wdata,
  input  wire dcache_pkg::lane_mask_t lane_mask,
  output logic                        stall,
  output logic                        resp_valid,
  output logic                        hit,
  output dcache_pkg::line_t           rdata,
  output dcache_pkg::index_t          A,
  output logic                        CEN,
  output logic                        GWEN,
  output dcache_pkg::line_t           WEN,
  output dcache_pkg::line_t           D,
  input  wire dcache_pkg::line_t      Q
);

  import dcache_pkg::*;

  // Request fields
  index_t req_index;
  tag_t   req_tag;

  // Decoded strobes
  logic do_load;
  logic do_store;
  logic do_fill;
  logic do_inval;

  // One valid flop per set
  logic [`DCACHE_SETS-1:0] valid_q;

  // Compare stage control
  logic s1_valid_q;
  logic s1_store_q;

  // Compare stage payload
  index_t     s1_index_q;
  tag_t       s1_tag_q;
  line_t      s1_wdata_q;
  lane_mask_t s1_mask_q;

  // Tag read back one cycle after request
  tag_t tag_rd;

  // Store replay
  logic  store_wr;
  line_t store_wen;

  // Low bits pick the set, the rest is the tag
  assign req_index = addr[`DCACHE_INDEX_W-1:0];
  assign req_tag   = addr[`DCACHE_ADDR_W-1:`DCACHE_INDEX_W];

  assign do_load  = req && (op == OP_LOAD);
  assign do_store = req && (op == OP_STORE);
  assign do_fill  = req && (op == OP_FILL);
  assign do_inval = req && (op == OP_INVAL);

  // Tag store, written on fill only
  // Read every cycle, result lines up with the compare stage
  fpga_ram #(
    .ADDR_WIDTH (`DCACHE_INDEX_W),
    .word_t     (tag_t)
  ) tag_ram_inst (
    .PortAClk         (CLK),
    .PortAAddr        (req_index),
    .PortADataIn      (req_tag),
    .PortAWriteEnable (do_fill),
    .PortADataOut     (tag_rd)
  );

  // Valid bits, reset empties the way
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
    end else if (do_fill) begin
      valid_q[req_index] <= 1'b1;
    end else if (do_inval) begin
      valid_q[req_index] <= 1'b0;
    end
  end

  // Loads and stores move into the compare stage
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid_q <= 1'b0;
      s1_store_q <= 1'b0;
    end else begin
      s1_valid_q <= do_load || do_store;
      s1_store_q <= do_store;
    end
  end

  always_ff @(posedge CLK) begin
    if (do_load || do_store) begin
      s1_index_q <= req_index;
      s1_tag_q   <= req_tag;
      s1_wdata_q <= wdata;
      s1_mask_q  <= lane_mask;
    end
  end

  // Response in the cycle after the request
  assign resp_valid = s1_valid_q;

  // Store holds the port for its write cycle
  assign stall = s1_store_q;

  // Valid set and stored tag equal to the request tag
  assign hit = valid_q[s1_index_q] && (tag_rd == s1_tag_q);

  // Line read at the request edge
  assign rdata = Q;

  // Write back only when the store hit
  assign store_wr = s1_store_q && hit;

  // Expand lane mask to active-low bit enables
  always_comb begin
    for (int k = 0; k < `DCACHE_LANES; k++) begin
      store_wen[k*`DCACHE_LANE_W +: `DCACHE_LANE_W] = {`DCACHE_LANE_W{~s1_mask_q[k]}};
    end
  end

  // Data SRAM port
  // Stall cycle replays the stored index, else the live request drives it
  always_comb begin
    if (store_wr) begin
      A    = s1_index_q;
      CEN  = 1'b0;
      GWEN = 1'b0;
      WEN  = store_wen;
      D    = s1_wdata_q;
    end else begin
      A    = req_index;
      // Invalidate leaves the data alone
      CEN  = !(do_load || do_store || do_fill);
      GWEN = !do_fill;
      // Fill writes every lane
      WEN  = do_fill ? '0 : '1;
      D    = wdata;
    end
  end

  // Requester has to wait out the stall cycle
  a_no_req_in_stall : assert property (
    @(posedge CLK) disable iff (!arst_n) stall |-> !req
  ) else $error("req raised while stall is high");

  // Only loads and stores answer, and their line came from a data SRAM read
  a_resp_after_access : assert property (
    @(posedge CLK) disable iff (!arst_n)
    resp_valid |-> $past(req && (op == OP_LOAD || op == OP_STORE) && !CEN && GWEN)
  ) else $error("resp_valid without a load or store read of the data SRAM");

endmodule

`default_nettype wire

// File: verilog/dcache_way_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_way_top (
  input  wire                         CLK,
  input  wire                         arst_n,
  input  wire                         req,
  input  wire dcache_pkg::dcache_op_e op,
  input  wire [`DCACHE_ADDR_W-1:0]    addr,
  input  wire dcache_pkg::line_t      wdata,
  input  wire dcache_pkg::lane_mask_t lane_mask,
  output wire                         stall,
  output wire                         resp_valid,
  output wire                         hit,
  output wire dcache_pkg::line_t      rdata
);

  import dcache_pkg::*;

  // Controller to data SRAM
  wire index_t sram_a;
  wire         sram_cen;
  wire         sram_gwen;
  wire line_t  sram_wen;
  wire line_t  sram_d;
  wire line_t  sram_q;

  // Request decode, tags, valid bits and compare
  dcache_way_ctrl dcache_way_ctrl_inst (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .req        (req),
    .op         (op),
    .addr       (addr),
    .wdata      (wdata),
    .lane_mask  (lane_mask),
    .stall      (stall),
    .resp_valid (resp_valid),
    .hit        (hit),
    .rdata      (rdata),
    .A          (sram_a),
    .CEN        (sram_cen),
    .GWEN       (sram_gwen),
    .WEN        (sram_wen),
    .D          (sram_d),
    .Q          (sram_q)
  );

  // Line data, one word per set
  ct_f_spsram_512x96 ct_f_spsram_512x96_inst (
    .CLK  (CLK),
    .A    (sram_a),
    .CEN  (sram_cen),
    .GWEN (sram_gwen),
    .WEN  (sram_wen),
    .D    (sram_d),
    .Q    (sram_q)
  );

endmodule

`default_nettype wire

// File: verilog/fpga_ram.sv
`timescale 1ns/100ps
`default_nettype none

module fpga_ram #(
  parameter int  ADDR_WIDTH = 9,
  parameter type word_t     = logic [23:0]
) (
  input  wire        PortAClk,
  input  wire [ADDR_WIDTH-1:0] PortAAddr,
  input  wire word_t PortADataIn,
  input  wire        PortAWriteEnable,
  output word_t      PortADataOut
);

  // Storage, maps onto block RAM
  word_t mem [2**ADDR_WIDTH];

  // Synchronous write
  always_ff @(posedge PortAClk) begin
    if (PortAWriteEnable) begin
      mem[PortAAddr] <= PortADataIn;
    end
  end

  // Registered read every edge
  // Read-before-write on a write cycle, so old word comes out
  always_ff @(posedge PortAClk) begin
    PortADataOut <= mem[PortAAddr];
  end

  // A write to an unknown address would corrupt the array
  a_wr_addr_known : assert property (
    @(posedge PortAClk) PortAWriteEnable |-> !$isunknown(PortAAddr)
  ) else $error("fpga_ram write with unknown address");

endmodule

`default_nettype wire
